//--- logic/issue_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// widths shared by the issue cluster
// the decoded opcode encoding
// dispatch, issue, result and cdb structs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package issue_pkg;

    // operand and result values
    typedef logic [31:0] data_t;

    // instruction address, carried through to the result
    typedef logic [31:0] addr_t;

    // producer tag that names the result an operand waits for
    typedef logic [5:0] tag_t;

    // decoded integer operations, one per alu function
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_SLL = 3'd5,
        OP_SRL = 3'd6,
        OP_SLT = 3'd7
    } opcode_t;

    // one decoded instruction as it enters the station
    // index 0 of each source array is operand a, index 1 is operand b
    typedef struct packed {
        opcode_t         opcode;
        addr_t           iaddr;
        logic [1:0]      src_rdy;
        data_t [1:0]     src_data;
        tag_t [1:0]      src_tag;
        tag_t            dst_tag;
    } dispatch_t;

    // an instruction with both operands resolved, sent to the alu
    typedef struct packed {
        opcode_t opcode;
        addr_t   iaddr;
        data_t   src_a;
        data_t   src_b;
        tag_t    dst_tag;
    } issue_t;

    // the alu output as it leaves the cluster
    typedef struct packed {
        addr_t iaddr;
        tag_t  tag;
        data_t data;
    } result_t;

    // broadcast that wakes operands waiting on tag
    typedef struct packed {
        logic  en;
        tag_t  tag;
        data_t data;
    } cdb_t;

endpackage

`default_nettype wire

//--- logic/age_pick.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// age matrix selector that picks the
// oldest ready slot, one-hot and binary
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module age_pick #(
    parameter int RS_DEPTH = 8
) (
    input  wire logic [$clog2(RS_DEPTH)-1:0] slot_age [RS_DEPTH],
    input  wire logic [RS_DEPTH-1:0]         rdy,
    output logic [RS_DEPTH-1:0]              sel_onehot,
    output logic [$clog2(RS_DEPTH)-1:0]      sel_index,
    output logic                             any_sel
);

    localparam int IDX_W = $clog2(RS_DEPTH);

    // slot number within the station
    typedef logic [IDX_W-1:0] slot_idx_t;

    // row i holds a one in column j when slot i is at least as old as slot j
    logic [RS_DEPTH-1:0] older [RS_DEPTH];

    // build the full comparison matrix
    // the diagonal is forced high so a slot never loses against itself
    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            for (int j = 0; j < RS_DEPTH; j++) begin
                if (i == j) begin
                    older[i][j] = 1'b1;
                end else begin
                    older[i][j] = slot_age[i] > slot_age[j];
                end
            end
        end
    end

    // a ready slot wins when it beats every other ready slot
    // columns of slots that are not ready are forced high so they never veto
    // occupied slots carry distinct ages so at most one bit can be set
    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            sel_onehot[i] = rdy[i] & (&(older[i] | ~rdy));
        end
    end

    // one-hot to binary by or-ing the index of every set bit
    always_comb begin
        slot_idx_t idx;
        idx = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (sel_onehot[i]) begin
                idx = idx | slot_idx_t'(i);
            end
        end
        sel_index = idx;
    end

    // something was picked this cycle
    assign any_sel = |sel_onehot;

endmodule

`default_nettype wire

//--- logic/reservation_station.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reservation station slot storage,
// free slot choice, age tracking, cdb
// wake-up and the issue handshake
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module reservation_station import issue_pkg::*; #(
    parameter int RS_DEPTH = 8
) (
    input  wire logic      clk,
    input  wire logic      n_rst,
    input  wire logic      flush,
    input  wire logic      dispatch_valid,
    input  wire dispatch_t dispatch,
    output logic           dispatch_ready,
    output logic           issue_valid,
    input  wire logic      issue_ready,
    output issue_t         issue,
    input  wire cdb_t      cdb
);

    localparam int IDX_W = $clog2(RS_DEPTH);

    // slot number, also used as the age of an occupied slot
    typedef logic [IDX_W-1:0] slot_idx_t;

    // slot payload, stored in the same layout as it was dispatched
    // the ready bits and data of each operand are updated by the cdb
    dispatch_t slot_q [RS_DEPTH];

    // one bit per slot, set while the slot holds nothing
    logic [RS_DEPTH-1:0] empty_q;

    // age 0 is the youngest, occupied slots hold ages 0 to count-1
    slot_idx_t age_q [RS_DEPTH];

    // slots that hold an instruction with both operands present
    logic [RS_DEPTH-1:0] rdy;

    // one-hot choices for the next dispatch and the next issue
    logic [RS_DEPTH-1:0] alloc_onehot;
    logic [RS_DEPTH-1:0] issue_onehot;

    // the same choices qualified by their handshakes
    logic [RS_DEPTH-1:0] alloc_set;
    logic [RS_DEPTH-1:0] issue_clr;

    slot_idx_t issue_idx;
    slot_idx_t issue_age;
    logic      any_rdy;
    logic      dispatching;
    logic      issuing;

    // dispatch payload after a same cycle cdb match has been folded in
    dispatch_t dispatch_cap;

    // a slot is eligible once it is occupied and both operands are present
    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            rdy[i] = !empty_q[i] && (&slot_q[i].src_rdy);
        end
    end

    // oldest eligible slot
    age_pick #(
        .RS_DEPTH (RS_DEPTH)
    ) age_pick_inst (
        .slot_age   (age_q),
        .rdy        (rdy),
        .sel_onehot (issue_onehot),
        .sel_index  (issue_idx),
        .any_sel    (any_rdy)
    );

    // lowest numbered empty slot, found by isolating the lowest set bit
    assign alloc_onehot = empty_q & ~(empty_q - RS_DEPTH'(1));

    // room for one more instruction while any slot is empty
    assign dispatch_ready = |empty_q;
    assign dispatching    = dispatch_valid && dispatch_ready;

    // offer an instruction whenever any slot can go
    assign issue_valid = any_rdy;
    assign issuing     = any_rdy && issue_ready;

    assign alloc_set = alloc_onehot & {RS_DEPTH{dispatching}};
    assign issue_clr = issue_onehot & {RS_DEPTH{issuing}};

    // age of the slot that leaves, which decides how the others move
    assign issue_age = age_q[issue_idx];

    // drive the alu from the selected slot
    always_comb begin
        issue.opcode  = slot_q[issue_idx].opcode;
        issue.iaddr   = slot_q[issue_idx].iaddr;
        issue.src_a   = slot_q[issue_idx].src_data[0];
        issue.src_b   = slot_q[issue_idx].src_data[1];
        issue.dst_tag = slot_q[issue_idx].dst_tag;
    end

    // an operand that arrives waiting on the tag being broadcast right now
    // takes the broadcast value, otherwise that wake-up would be missed
    always_comb begin
        dispatch_cap = dispatch;
        for (int k = 0; k < 2; k++) begin
            if (!dispatch.src_rdy[k] && cdb.en && (cdb.tag == dispatch.src_tag[k])) begin
                dispatch_cap.src_rdy[k]  = 1'b1;
                dispatch_cap.src_data[k] = cdb.data;
            end
        end
    end

    // occupancy and age tracking
    // the allocated slot is always empty and the issuing slot never is,
    // so one slot cannot be freed and refilled at the same edge
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            empty_q <= '1;
            for (int i = 0; i < RS_DEPTH; i++) begin
                age_q[i] <= '0;
            end
        end else if (flush) begin
            // a flush drops everything, including a dispatch in the same cycle
            empty_q <= '1;
            for (int i = 0; i < RS_DEPTH; i++) begin
                age_q[i] <= '0;
            end
        end else begin
            empty_q <= (empty_q | issue_clr) & ~alloc_set;
            for (int i = 0; i < RS_DEPTH; i++) begin
                case ({dispatching, issuing})
                    // new entry is youngest, everything else gets one older
                    2'b10: begin
                        if (alloc_set[i]) begin
                            age_q[i] <= '0;
                        end else begin
                            age_q[i] <= age_q[i] + 1'b1;
                        end
                    end
                    // close the gap left by the issuing slot
                    2'b01: begin
                        if (age_q[i] > issue_age) begin
                            age_q[i] <= age_q[i] - 1'b1;
                        end
                    end
                    // only the slots younger than the leaving one shift up
                    2'b11: begin
                        if (alloc_set[i]) begin
                            age_q[i] <= '0;
                        end else if (age_q[i] < issue_age) begin
                            age_q[i] <= age_q[i] + 1'b1;
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // payload storage and operand wake-up
    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (alloc_set[i]) begin
                slot_q[i] <= dispatch_cap;
            end else begin
                // a waiting operand grabs the broadcast on a tag match
                // operands already present keep their value
                for (int k = 0; k < 2; k++) begin
                    if (!slot_q[i].src_rdy[k] && cdb.en &&
                        (cdb.tag == slot_q[i].src_tag[k])) begin
                        slot_q[i].src_rdy[k]  <= 1'b1;
                        slot_q[i].src_data[k] <= cdb.data;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/int_alu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// single stage integer alu with output
// register, result handshake and cdb
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module int_alu import issue_pkg::*; (
    input  wire logic   clk,
    input  wire logic   n_rst,
    input  wire logic   flush,
    input  wire logic   issue_valid,
    output logic        issue_ready,
    input  wire issue_t issue,
    output logic        result_valid,
    input  wire logic   result_ready,
    output result_t     result,
    output cdb_t        cdb
);

    data_t   alu_out;
    logic    issue_fire;
    logic    result_fire;
    logic    res_valid_q;
    result_t res_q;

    // the operation itself, shifts use only the low five bits of b
    always_comb begin
        case (issue.opcode)
            OP_ADD:  alu_out = issue.src_a + issue.src_b;
            OP_SUB:  alu_out = issue.src_a - issue.src_b;
            OP_AND:  alu_out = issue.src_a & issue.src_b;
            OP_OR:   alu_out = issue.src_a | issue.src_b;
            OP_XOR:  alu_out = issue.src_a ^ issue.src_b;
            OP_SLL:  alu_out = issue.src_a << issue.src_b[4:0];
            OP_SRL:  alu_out = issue.src_a >> issue.src_b[4:0];
            // signed compare, result is 1 or 0
            OP_SLT:  alu_out = data_t'($signed(issue.src_a) < $signed(issue.src_b));
            default: alu_out = '0;
        endcase
    end

    // the register can take a new result when empty or when it drains now
    assign issue_ready = !res_valid_q || result_ready;
    assign issue_fire  = issue_valid && issue_ready;
    assign result_fire = res_valid_q && result_ready;

    // output register occupancy, a flush discards both the held result
    // and anything issued in the same cycle
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            res_valid_q <= 1'b0;
        end else if (flush) begin
            res_valid_q <= 1'b0;
        end else if (issue_fire) begin
            res_valid_q <= 1'b1;
        end else if (result_fire) begin
            res_valid_q <= 1'b0;
        end
    end

    // the result payload only changes on a new issue, so it holds while stalled
    always_ff @(posedge clk) begin
        if (issue_fire) begin
            res_q.iaddr <= issue.iaddr;
            res_q.tag   <= issue.dst_tag;
            res_q.data  <= alu_out;
        end
    end

    assign result_valid = res_valid_q;
    assign result       = res_q;

    // broadcast exactly when the result is taken by the outside
    always_comb begin
        cdb.en   = result_fire;
        cdb.tag  = res_q.tag;
        cdb.data = res_q.data;
    end

endmodule

`default_nettype wire

//--- logic/issue_cluster.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// issue cluster top level with station,
// alu and the cdb feedback path
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module issue_cluster import issue_pkg::*; #(
    parameter int RS_DEPTH = 8
) (
    input  wire logic      clk,
    input  wire logic      n_rst,
    input  wire logic      flush,
    input  wire logic      dispatch_valid,
    input  wire dispatch_t dispatch,
    output logic           dispatch_ready,
    output logic           result_valid,
    output result_t        result,
    input  wire logic      result_ready
);

    // station to alu link
    logic   issue_valid;
    logic   issue_ready;
    issue_t issue;

    // alu broadcast, fed back to wake waiting operands
    cdb_t cdb;

    reservation_station #(
        .RS_DEPTH (RS_DEPTH)
    ) reservation_station_inst (
        .clk            (clk),
        .n_rst          (n_rst),
        .flush          (flush),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .dispatch_ready (dispatch_ready),
        .issue_valid    (issue_valid),
        .issue_ready    (issue_ready),
        .issue          (issue),
        .cdb            (cdb)
    );

    int_alu int_alu_inst (
        .clk          (clk),
        .n_rst        (n_rst),
        .flush        (flush),
        .issue_valid  (issue_valid),
        .issue_ready  (issue_ready),
        .issue        (issue),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result       (result),
        .cdb          (cdb)
    );

endmodule

`default_nettype wire

//--- verif/tb_issue_cluster.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the issue cluster with a
// stimulus table, a reference alu model
// and result and flag compare tasks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module tb_issue_cluster import issue_pkg::*; ();

    localparam int          RS_DEPTH = 8;
    localparam int          TIMEOUT  = 200;
    localparam int unsigned RND_SEED = 32'h66f4ec97;

    // how result_ready behaves while a group runs
    localparam logic [1:0] RR_HIGH = 2'd0;
    localparam logic [1:0] RR_RAND = 2'd1;
    localparam logic [1:0] RR_HOLD = 2'd2;

    // one table row, pos is where its result leaves within the group
    typedef struct packed {
        logic [7:0] grp;
        logic [1:0] rr_mode;
        logic       flush_after;
        logic [7:0] pos;
        dispatch_t  disp;
        result_t    exp;
    } entry_t;

    logic      clk;
    logic      n_rst;
    logic      flush;
    logic      dispatch_valid;
    dispatch_t dispatch;
    logic      dispatch_ready;
    logic      result_valid;
    result_t   result;
    logic      result_ready;

    entry_t      tbl[$];
    int          first;
    int          last;

    issue_cluster #(
        .RS_DEPTH (RS_DEPTH)
    ) issue_cluster_inst (
        .clk            (clk),
        .n_rst          (n_rst),
        .flush          (flush),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .dispatch_ready (dispatch_ready),
        .result_valid   (result_valid),
        .result         (result),
        .result_ready   (result_ready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // expected alu value, written from the opcode definitions
    function automatic data_t ref_alu(opcode_t op, data_t a, data_t b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << b[4:0];
            OP_SRL:  return a >> b[4:0];
            OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return '0;
        endcase
    endfunction

    // a waiting operand takes the expected result of the entry producing its tag
    function automatic data_t operand_value(dispatch_t d, int k);
        if (d.src_rdy[k]) begin
            return d.src_data[k];
        end
        foreach (tbl[j]) begin
            if (tbl[j].disp.dst_tag == d.src_tag[k]) begin
                return tbl[j].exp.data;
            end
        end
        return '0;
    endfunction

    // iaddr and dst_tag come from the table position, tags start at 1
    task automatic add_entry(int grp, logic [1:0] mode, logic fl, int pos, opcode_t op,
                             logic [1:0] rdy, data_t a, data_t b, int ta, int tb);
        entry_t e;
        e = '0;
        e.grp              = 8'(grp);
        e.rr_mode          = mode;
        e.flush_after      = fl;
        e.pos              = 8'(pos);
        e.disp.opcode      = op;
        e.disp.iaddr       = addr_t'(32'h1000 + 4 * tbl.size());
        e.disp.src_rdy     = rdy;
        e.disp.src_data[0] = rdy[0] ? a : 32'hdead_beef;
        e.disp.src_data[1] = rdy[1] ? b : 32'hdead_beef;
        e.disp.src_tag[0]  = tag_t'(ta);
        e.disp.src_tag[1]  = tag_t'(tb);
        e.disp.dst_tag     = tag_t'(tbl.size() + 1);
        tbl.push_back(e);
    endtask

    // two passes cover a producer that sits later in the table
    task automatic resolve_expected();
        entry_t e;
        repeat (2) begin
            for (int i = 0; i < tbl.size(); i++) begin
                e = tbl[i];
                e.exp.iaddr = e.disp.iaddr;
                e.exp.tag   = e.disp.dst_tag;
                e.exp.data  = ref_alu(e.disp.opcode, operand_value(e.disp, 0),
                                      operand_value(e.disp, 1));
                tbl[i] = e;
            end
        end
    endtask

    task automatic build_table();
        // nine ready ops into a stalled output, every opcode plus one more add
        for (int i = 0; i < 9; i++) begin
            add_entry(0, RR_HOLD, 1'b0, i, opcode_t'(i % 8), 2'b11,
                      data_t'(32'h9e37_79b9 * (i + 1)), data_t'(i * 7 + 3), 0, 0);
        end
        // one of each opcode, shift amounts carry junk above bit 4
        add_entry(1, RR_HIGH, 1'b0, 0, OP_ADD, 2'b11, 32'hffff_fff0, 32'h0000_0025, 0, 0);
        add_entry(1, RR_HIGH, 1'b0, 1, OP_SUB, 2'b11, 32'h0000_0010, 32'h0000_0020, 0, 0);
        add_entry(1, RR_HIGH, 1'b0, 2, OP_AND, 2'b11, 32'hf0f0_a5a5, 32'h0ff0_ffff, 0, 0);
        add_entry(1, RR_HIGH, 1'b0, 3, OP_OR,  2'b11, 32'h1200_0034, 32'h0056_7800, 0, 0);
        add_entry(1, RR_HIGH, 1'b0, 4, OP_XOR, 2'b11, 32'haaaa_5555, 32'hffff_0000, 0, 0);
        add_entry(1, RR_HIGH, 1'b0, 5, OP_SLL, 2'b11, 32'h8000_0003, 32'h0000_0124, 0, 0);
        add_entry(1, RR_HIGH, 1'b0, 6, OP_SRL, 2'b11, 32'h8000_0000, 32'hffff_ffff, 0, 0);
        add_entry(1, RR_HIGH, 1'b0, 7, OP_SLT, 2'b11, 32'hffff_fffe, 32'h0000_0001, 0, 0);
        // the oldest entry waits on tag 20 from the youngest, so it leaves last
        add_entry(2, RR_HIGH, 1'b0, 2, OP_ADD, 2'b10, 32'h0, 32'h0000_0100, 20, 0);
        add_entry(2, RR_HIGH, 1'b0, 0, OP_XOR, 2'b11, 32'h0000_ffff, 32'h0000_00ff, 0, 0);
        add_entry(2, RR_HIGH, 1'b0, 1, OP_SUB, 2'b11, 32'h0000_5000, 32'h0000_0123, 0, 0);
        // dependency chain on tags 21, 22 and 23 under random stalls
        add_entry(3, RR_RAND, 1'b0, 0, OP_ADD, 2'b11, 32'h0000_0007, 32'h0000_0009, 0, 0);
        add_entry(3, RR_RAND, 1'b0, 1, OP_SLL, 2'b10, 32'h0, 32'h0000_0003, 21, 0);
        add_entry(3, RR_RAND, 1'b0, 2, OP_SUB, 2'b01, 32'h0000_1000, 32'h0, 0, 22);
        add_entry(3, RR_RAND, 1'b0, 3, OP_SLT, 2'b10, 32'h0, 32'h0000_1000, 23, 0);
        // three ops that get flushed, then one that must still complete
        for (int i = 0; i < 3; i++) begin
            add_entry(4, RR_HOLD, i == 2, i, OP_OR, 2'b11, data_t'(i), 32'h0000_0f00, 0, 0);
        end
        add_entry(5, RR_HIGH, 1'b0, 0, OP_AND, 2'b11, 32'h1234_5678, 32'h00ff_ff00, 0, 0);
        resolve_expected();
    endtask

    task automatic compare_result(string name, result_t exp, result_t act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %h, actual %h", $time, name, exp, act);
            $display("Test FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic compare_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %b, actual %b", $time, name, exp, act);
            $display("Test FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic report_timeout(string what);
        $display("Timeout at %0t: %s did not arrive within %0d cycles", $time, what, TIMEOUT);
        $display("Test FAILED");
        $fatal(1, "timeout waiting for %s", what);
    endtask

    // strict means every entry must find a free slot straight away
    task automatic dispatch_group(int lo, int hi, logic strict);
        int cnt;
        for (int i = lo; i <= hi; i++) begin
            @(posedge clk);
            #2;
            dispatch_valid = 1'b1;
            dispatch       = tbl[i].disp;
            cnt            = 0;
            if (strict) begin
                compare_flag("dispatch_ready", 1'b1, dispatch_ready);
            end
            while (!dispatch_ready) begin
                cnt++;
                if (cnt > TIMEOUT) begin
                    report_timeout("dispatch_ready");
                end
                @(posedge clk);
                #2;
            end
        end
        @(posedge clk);
        #2;
        dispatch_valid = 1'b0;
    endtask

    // the handshake lands on the edge after each sample
    task automatic collect_group(int lo, int hi, logic [1:0] mode);
        result_t exp_q[$];
        result_t held_val;
        logic    held;
        logic    rr;
        int      cnt;
        for (int p = 0; p <= hi - lo; p++) begin
            for (int i = lo; i <= hi; i++) begin
                if (int'(tbl[i].pos) == p) begin
                    exp_q.push_back(tbl[i].exp);
                end
            end
        end
        held = 1'b0;
        cnt  = 0;
        while (exp_q.size() > 0) begin
            @(posedge clk);
            #2;
            rr = (mode == RR_RAND) ? (($urandom % 4) != 0) : 1'b1;
            result_ready = rr;
            // a stalled result must still be there, unchanged
            if (held) begin
                compare_flag("result_valid", 1'b1, result_valid);
                compare_result("result", held_val, result);
            end
            held = 1'b0;
            if (result_valid && rr) begin
                compare_result("result", exp_q.pop_front(), result);
                cnt = 0;
            end else if (result_valid) begin
                held     = 1'b1;
                held_val = result;
            end
            cnt++;
            if (cnt > TIMEOUT) begin
                report_timeout("result_valid");
            end
        end
        // the last result is only taken at the next edge, so wait for it
        @(posedge clk);
        #2;
    endtask

    task automatic run_group(int lo, int hi);
        if (tbl[lo].rr_mode == RR_HOLD) begin
            result_ready = 1'b0;
            dispatch_group(lo, hi, 1'b1);
            if (tbl[hi].flush_after) begin
                flush = 1'b1;
                @(posedge clk);
                #2;
                flush        = 1'b0;
                result_ready = 1'b1;
                // nothing flushed comes out and every slot is free again
                repeat (20) begin
                    @(posedge clk);
                    #2;
                    compare_flag("result_valid", 1'b0, result_valid);
                    compare_flag("dispatch_ready", 1'b1, dispatch_ready);
                end
            end else begin
                // alu register plus all RS_DEPTH slots hold an op now
                compare_flag("dispatch_ready", 1'b0, dispatch_ready);
                collect_group(lo, hi, RR_HIGH);
            end
        end else begin
            fork
                dispatch_group(lo, hi, 1'b0);
                collect_group(lo, hi, tbl[lo].rr_mode);
            join
        end
    endtask

    initial begin
        n_rst          = 1'b0;
        flush          = 1'b0;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        result_ready   = 1'b0;
        void'($urandom(RND_SEED));
        build_table();
        repeat (2) @(posedge clk);
        #2;
        n_rst = 1'b1;
        // idle state right out of reset
        compare_flag("dispatch_ready", 1'b1, dispatch_ready);
        compare_flag("result_valid", 1'b0, result_valid);
        first = 0;
        while (first < tbl.size()) begin
            last = first;
            while (last + 1 < tbl.size() && tbl[last + 1].grp == tbl[first].grp) begin
                last++;
            end
            run_group(first, last);
            first = last + 1;
        end
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- issue_cluster.f
logic/issue_pkg.sv
logic/age_pick.sv
logic/reservation_station.sv
logic/int_alu.sv
logic/issue_cluster.sv
verif/tb_issue_cluster.sv

//--- Makefile
# Verilator build, run, lint and clean for the issue cluster
VERILATOR ?= verilator
TOP       ?= tb_issue_cluster
RTL_TOP   ?= issue_cluster
FILELIST  ?= issue_cluster.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?=
RTL_SRCS  ?= logic/issue_pkg.sv logic/age_pick.sv logic/reservation_station.sv \
             logic/int_alu.sv logic/issue_cluster.sv
TB_SRCS   ?= verif/tb_issue_cluster.sv

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(RTL_SRCS) $(TB_SRCS)
	$(VERILATOR) --binary --timing $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(OBJ_DIR)/V$(TOP)
	@out="$$($(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)
